//--- hdl/battle_types_pkg.sv
package battle_types_pkg;

    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } coord_t;

    // Two bits per cell with the ship flag above the hit flag
    typedef struct packed {
        logic ship;  // Part of a ship
        logic hit;   // Already fired at
    } cell_t;

    typedef enum logic {
        op_place = 1'b0,
        op_fire  = 1'b1
    } board_op_e;

    typedef struct packed {
        logic       valid;
        board_op_e  op;
        coord_t     coord;   // Ship start or shot cell
        logic [2:0] length;  // Ship length for placements
    } board_cmd_t;

    typedef struct packed {
        logic      valid;
        board_op_e op;
        logic      accepted;  // Ship written to the board
        logic      hit;       // Shot struck a live ship cell
    } board_resp_t;

endpackage

//--- hdl/game_ctrl_pkg.sv
package game_ctrl_pkg;

    typedef enum logic [2:0] {
        st_setup_home   = 3'd0,  // Player fleet placement
        st_setup_target = 3'd1,  // Opponent fleet placement
        st_player_turn  = 3'd2,
        st_pc_turn      = 3'd3,
        st_game_over    = 3'd4
    } game_state_e;

    typedef enum logic [1:0] {
        win_none   = 2'd0,
        win_player = 2'd1,
        win_pc     = 2'd2
    } winner_e;

endpackage

//--- hdl/fleet_board.sv
`timescale 1ns/1ps

module fleet_board
    import battle_types_pkg::*;
#(
    parameter int BOARD_DIM  = 5,
    parameter int FLEET_SIZE = 3
) (
    input  logic                            clock,
    input  logic                            reset,
    input  board_cmd_t                      cmd,
    output board_resp_t                     resp,
    output cell_t [BOARD_DIM*BOARD_DIM-1:0] cells,
    output logic [5:0]                      afloat
);

    logic [6:0] base_idx;  // Flat index of the command cell
    logic       in_range;
    logic       fits;
    logic       overlap;
    logic       place_ok;
    logic       shot_hit;

    assign base_idx = 7'(cmd.coord.row * BOARD_DIM + cmd.coord.col);

    assign in_range = (int'(cmd.coord.row) < BOARD_DIM) &&
                      (int'(cmd.coord.col) < BOARD_DIM);

    // Ship must end inside the row it starts in
    assign fits = in_range &&
                  (int'(cmd.coord.col) + int'(cmd.length) <= BOARD_DIM);

    // Any covered cell that already holds a ship blocks the placement
    always_comb begin
        overlap = 1'b0;
        for (int k = 0; k < BOARD_DIM; k++) begin
            if (fits && (k < int'(cmd.length))) begin
                overlap = overlap | cells[int'(base_idx) + k].ship;
            end
        end
    end

    assign place_ok = fits && !overlap;

    always_comb begin
        shot_hit = 1'b0;
        if (in_range) begin
            shot_hit = cells[base_idx].ship && !cells[base_idx].hit;  // Live ship cell
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cells  <= '0;
            afloat <= 6'd0;
            resp   <= '0;
        end else begin
            resp.valid    <= cmd.valid;  // Fixed one-cycle response
            resp.op       <= cmd.op;
            resp.accepted <= 1'b0;
            resp.hit      <= 1'b0;

            if (cmd.valid && (cmd.op == op_place)) begin
                if (place_ok) begin
                    for (int k = 0; k < BOARD_DIM; k++) begin
                        if (k < int'(cmd.length)) begin
                            cells[int'(base_idx) + k].ship <= 1'b1;
                        end
                    end
                    afloat        <= afloat + 6'(cmd.length);
                    resp.accepted <= 1'b1;
                end
            end else if (cmd.valid && (cmd.op == op_fire)) begin
                if (in_range) begin
                    cells[base_idx].hit <= 1'b1;  // Repeat shots leave it set
                end
                if (shot_hit) begin
                    afloat   <= afloat - 6'd1;
                    resp.hit <= 1'b1;
                end
            end
        end
    end

    // The sequencer hands out lengths from FLEET_SIZE down to one
    a_place_length: assert property (
        @(posedge clock) disable iff (reset)
        (cmd.valid && (cmd.op == op_place)) |->
            ((cmd.length != 3'd0) && (int'(cmd.length) <= FLEET_SIZE))
    );

endmodule

//--- hdl/shot_lfsr.sv
`timescale 1ns/1ps

module shot_lfsr
    import battle_types_pkg::*;
#(
    parameter int         BOARD_DIM = 5,
    parameter logic [7:0] LFSR_SEED = 8'hA5
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   next_shot,
    output coord_t pc_target
);

    localparam logic [7:0] CELLS = 8'(BOARD_DIM * BOARD_DIM);
    localparam logic [7:0] DIM   = 8'(BOARD_DIM);

    logic [7:0] lfsr;
    logic       feedback;
    logic [7:0] cell_idx;

    // Taps 7, 5, 4, 3 give a maximal length sequence
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (next_shot) begin
            lfsr <= {lfsr[6:0], feedback};  // Shift left, feed bit 0
        end
    end

    // Fold the register onto the board
    assign cell_idx = lfsr % CELLS;

    assign pc_target.row = 3'(cell_idx / DIM);
    assign pc_target.col = 3'(cell_idx % DIM);

    // A non-zero seed keeps the register out of the lock-up state
    a_lfsr_nonzero: assert property (
        @(posedge clock) disable iff (reset)
        lfsr != 8'd0
    );

endmodule

//--- hdl/game_sequencer.sv
`timescale 1ns/1ps

module game_sequencer
    import battle_types_pkg::*, game_ctrl_pkg::*;
#(
    parameter int FLEET_SIZE = 3
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        place_button,
    input  logic        fire_button,
    input  coord_t      target,
    input  coord_t      pc_target,
    input  board_resp_t home_resp,
    input  board_resp_t target_resp,
    input  logic [5:0]  home_afloat,
    input  logic [5:0]  target_afloat,
    output board_cmd_t  home_cmd,
    output board_cmd_t  target_cmd,
    output logic        next_shot,
    output game_state_e game_state,
    output winner_e     winner
);

    logic       place_q;
    logic       fire_q;
    logic       place_edge;
    logic       fire_edge;
    logic       busy;      // Command in flight until its response
    logic [2:0] ship_cnt;  // Ships accepted in this setup phase
    logic [2:0] ship_len;

    function automatic board_cmd_t make_cmd(board_op_e op, coord_t coord, logic [2:0] length);
        board_cmd_t c;
        c.valid  = 1'b1;
        c.op     = op;
        c.coord  = coord;
        c.length = length;
        return c;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            place_q <= 1'b0;
            fire_q  <= 1'b0;
        end else begin
            place_q <= place_button;
            fire_q  <= fire_button;
        end
    end

    assign place_edge = place_button && !place_q;
    assign fire_edge  = fire_button && !fire_q;

    assign ship_len = 3'(FLEET_SIZE) - ship_cnt;  // Largest ship first

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            game_state <= st_setup_home;
            winner     <= win_none;
            busy       <= 1'b0;
            ship_cnt   <= 3'd0;
            home_cmd   <= '0;
            target_cmd <= '0;
            next_shot  <= 1'b0;
        end else begin
            home_cmd.valid   <= 1'b0;  // Commands are single-cycle pulses
            target_cmd.valid <= 1'b0;
            next_shot        <= 1'b0;

            case (game_state)
                st_setup_home: begin
                    if (!busy && place_edge) begin
                        home_cmd <= make_cmd(op_place, target, ship_len);
                        busy     <= 1'b1;
                    end else if (home_resp.valid) begin
                        busy <= 1'b0;
                        if (home_resp.accepted) begin
                            if (ship_cnt == 3'(FLEET_SIZE - 1)) begin
                                ship_cnt   <= 3'd0;
                                game_state <= st_setup_target;
                            end else begin
                                ship_cnt <= ship_cnt + 3'd1;
                            end
                        end
                    end
                end

                st_setup_target: begin
                    if (!busy && place_edge) begin
                        target_cmd <= make_cmd(op_place, target, ship_len);
                        busy       <= 1'b1;
                    end else if (target_resp.valid) begin
                        busy <= 1'b0;
                        if (target_resp.accepted) begin
                            if (ship_cnt == 3'(FLEET_SIZE - 1)) begin
                                ship_cnt   <= 3'd0;
                                game_state <= st_player_turn;
                            end else begin
                                ship_cnt <= ship_cnt + 3'd1;
                            end
                        end
                    end
                end

                st_player_turn: begin
                    if (!busy && fire_edge) begin
                        target_cmd <= make_cmd(op_fire, target, 3'd0);
                        busy       <= 1'b1;
                    end else if (target_resp.valid) begin
                        busy <= 1'b0;
                        if (target_afloat == 6'd0) begin  // Count already updated
                            game_state <= st_game_over;
                            winner     <= win_player;
                        end else begin
                            game_state <= st_pc_turn;
                        end
                    end
                end

                st_pc_turn: begin
                    if (!busy) begin
                        home_cmd  <= make_cmd(op_fire, pc_target, 3'd0);
                        next_shot <= 1'b1;  // LFSR steps after the coordinate is latched
                        busy      <= 1'b1;
                    end else if (home_resp.valid) begin
                        busy <= 1'b0;
                        if (home_afloat == 6'd0) begin
                            game_state <= st_game_over;
                            winner     <= win_pc;
                        end else begin
                            game_state <= st_player_turn;
                        end
                    end
                end

                st_game_over: begin
                    // Final state where buttons do nothing
                end

                default: begin
                    game_state <= st_setup_home;
                end
            endcase
        end
    end

    // Neither board sees another command once the game is decided
    a_idle_after_game: assert property (
        @(posedge clock) disable iff (reset)
        (game_state == st_game_over) |->
            (!home_cmd.valid && !target_cmd.valid &&
             !home_resp.valid && !target_resp.valid)
    );

endmodule

//--- hdl/battleship_top.sv
`timescale 1ns/1ps

module battleship_top
    import battle_types_pkg::*, game_ctrl_pkg::*;
#(
    parameter int         BOARD_DIM  = 5,
    parameter int         FLEET_SIZE = 3,
    parameter logic [7:0] LFSR_SEED  = 8'hA5
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            place_button,
    input  logic                            fire_button,
    input  coord_t                          target,
    output game_state_e                     game_state,
    output winner_e                         winner,
    output cell_t [BOARD_DIM*BOARD_DIM-1:0] home_view,
    output cell_t [BOARD_DIM*BOARD_DIM-1:0] target_view,
    output logic [5:0]                      home_afloat,
    output logic [5:0]                      target_afloat,
    output board_resp_t                     player_result,  // Target board response
    output board_resp_t                     pc_result       // Home board response
);

    board_cmd_t home_cmd;
    board_cmd_t target_cmd;
    logic       next_shot;
    coord_t     pc_target;

    game_sequencer #(
        .FLEET_SIZE (FLEET_SIZE)
    ) u_sequencer (
        .clock         (clock),
        .reset         (reset),
        .place_button  (place_button),
        .fire_button   (fire_button),
        .target        (target),
        .pc_target     (pc_target),
        .home_resp     (pc_result),
        .target_resp   (player_result),
        .home_afloat   (home_afloat),
        .target_afloat (target_afloat),
        .home_cmd      (home_cmd),
        .target_cmd    (target_cmd),
        .next_shot     (next_shot),
        .game_state    (game_state),
        .winner        (winner)
    );

    // Player fleet, fired on by the machine
    fleet_board #(
        .BOARD_DIM  (BOARD_DIM),
        .FLEET_SIZE (FLEET_SIZE)
    ) home_board (
        .clock  (clock),
        .reset  (reset),
        .cmd    (home_cmd),
        .resp   (pc_result),
        .cells  (home_view),
        .afloat (home_afloat)
    );

    // Opponent fleet, fired on by the player
    fleet_board #(
        .BOARD_DIM  (BOARD_DIM),
        .FLEET_SIZE (FLEET_SIZE)
    ) target_board (
        .clock  (clock),
        .reset  (reset),
        .cmd    (target_cmd),
        .resp   (player_result),
        .cells  (target_view),
        .afloat (target_afloat)
    );

    shot_lfsr #(
        .BOARD_DIM (BOARD_DIM),
        .LFSR_SEED (LFSR_SEED)
    ) u_shot_lfsr (
        .clock     (clock),
        .reset     (reset),
        .next_shot (next_shot),
        .pc_target (pc_target)
    );

endmodule

//--- sim/battleship_tb.sv
`timescale 1ns/1ps

module battleship_tb
    import battle_types_pkg::*, game_ctrl_pkg::*;
();

    localparam int         BOARD_DIM  = 5;
    localparam int         FLEET_SIZE = 3;
    localparam logic [7:0] LFSR_SEED  = 8'hA5;
    localparam int         NCELL      = BOARD_DIM * BOARD_DIM;
    localparam int         MAX_CYCLES = 20000;  // Setup plus about 60 turns, wide margin

    typedef cell_t [NCELL-1:0] view_t;

    logic        clock;
    logic        reset;
    logic        place_button;
    logic        fire_button;
    coord_t      target;
    game_state_e game_state;
    winner_e     winner;
    view_t       home_view;
    view_t       target_view;
    logic [5:0]  home_afloat;
    logic [5:0]  target_afloat;
    board_resp_t player_result;
    board_resp_t pc_result;

    view_t       m_home;  // Reference model of both boards and the game
    view_t       m_target;
    logic [5:0]  m_home_afloat;
    logic [5:0]  m_target_afloat;
    game_state_e m_state;
    winner_e     m_winner;
    logic [7:0]  m_lfsr;
    int          m_ships;

    board_resp_t exp_player_q[$];
    board_resp_t exp_pc_q[$];
    int          resp_count;
    int          errors;
    int          checks;
    int          tests;
    int          failed_tests;
    int          mark;
    int          cycle_count;
    integer      seed;

    battleship_top #(
        .BOARD_DIM  (BOARD_DIM),
        .FLEET_SIZE (FLEET_SIZE),
        .LFSR_SEED  (LFSR_SEED)
    ) dut (
        .clock         (clock),
        .reset         (reset),
        .place_button  (place_button),
        .fire_button   (fire_button),
        .target        (target),
        .game_state    (game_state),
        .winner        (winner),
        .home_view     (home_view),
        .target_view   (target_view),
        .home_afloat   (home_afloat),
        .target_afloat (target_afloat),
        .player_result (player_result),
        .pc_result     (pc_result)
    );

    function automatic coord_t coord_of(int r, int c);
        coord_t p;
        p.row = 3'(r);
        p.col = 3'(c);
        return p;
    endfunction

    function automatic int cell_index(coord_t c);
        return int'(c.row) * BOARD_DIM + int'(c.col);
    endfunction

    function automatic board_resp_t make_resp(board_op_e op, bit accepted, bit hit);
        board_resp_t r;
        r.valid    = 1'b1;
        r.op       = op;
        r.accepted = accepted;
        r.hit      = hit;
        return r;
    endfunction

    // Ship stays in its row and covers only water
    function automatic bit place_verdict(view_t board, coord_t c, int len);
        bit ok;
        ok = (int'(c.row) < BOARD_DIM) && (int'(c.col) + len <= BOARD_DIM);
        if (ok) begin
            for (int k = 0; k < len; k++) begin
                if (board[cell_index(c) + k].ship) ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic bit shot_outcome(view_t board, coord_t c);
        return board[cell_index(c)].ship && !board[cell_index(c)].hit;
    endfunction

    function automatic logic [7:0] lfsr_next(logic [7:0] v);
        return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
    endfunction

    function automatic coord_t lfsr_coord(logic [7:0] v);
        int idx;
        idx = int'(v) % NCELL;
        return coord_of(idx / BOARD_DIM, idx % BOARD_DIM);
    endfunction

    task automatic note_failure(string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic compare_resp(string name, board_resp_t got, board_resp_t expected);
        checks++;
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic compare_cells(string name, view_t got, view_t expected);
        checks++;
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic compare_count(string name, logic [5:0] got, logic [5:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic compare_state(game_state_e got_state, game_state_e exp_state,
                                 winner_e got_winner, winner_e exp_winner);
        checks++;
        if (got_state !== exp_state) begin
            $display("Mismatch game_state: got %h, expected %h", got_state, exp_state);
            errors++;
        end
        if (got_winner !== exp_winner) begin
            $display("Mismatch winner: got %h, expected %h", got_winner, exp_winner);
            errors++;
        end
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors == mark) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed with %0d errors", tests, name, errors - mark);
        end
        mark = errors;
    endtask

    // One-cycle press, called on a falling edge
    task automatic press_button(bit fire, coord_t c);
        target = c;
        if (fire) fire_button = 1'b1;
        else place_button = 1'b1;
        @(negedge clock);
        fire_button  = 1'b0;
        place_button = 1'b0;
    endtask

    task automatic place_ship(coord_t c);
        view_t       board;
        game_state_e st;
        int          len;
        int          start;
        bit          ok;
        st    = m_state;
        board = (st == st_setup_home) ? m_home : m_target;
        len   = FLEET_SIZE - m_ships;
        ok    = place_verdict(board, c, len);
        if (ok) begin
            for (int k = 0; k < len; k++) board[cell_index(c) + k].ship = 1'b1;
            m_ships++;
        end
        if (st == st_setup_home) begin
            m_home = board;
            if (ok) m_home_afloat = m_home_afloat + 6'(len);
            exp_pc_q.push_back(make_resp(op_place, ok, 1'b0));  // Home board answers on pc_result
        end else begin
            m_target = board;
            if (ok) m_target_afloat = m_target_afloat + 6'(len);
            exp_player_q.push_back(make_resp(op_place, ok, 1'b0));
        end
        if (m_ships == FLEET_SIZE) begin
            m_ships = 0;
            m_state = (st == st_setup_home) ? st_setup_target : st_player_turn;
        end
        start = resp_count;
        press_button(1'b0, c);
        wait (resp_count != start);
        @(negedge clock);
        compare_state(game_state, m_state, winner, m_winner);
    endtask

    // Player shot, followed by the machine reply unless the game ends
    task automatic fire_shot(coord_t c);
        coord_t pc;
        int     start;
        bit     hit;
        hit = shot_outcome(m_target, c);
        m_target[cell_index(c)].hit = 1'b1;
        if (hit) m_target_afloat = m_target_afloat - 6'd1;
        exp_player_q.push_back(make_resp(op_fire, 1'b0, hit));
        start = resp_count;
        press_button(1'b1, c);
        wait (resp_count != start);
        @(negedge clock);
        if (m_target_afloat == 6'd0) begin
            m_state  = st_game_over;
            m_winner = win_player;
            compare_state(game_state, m_state, winner, m_winner);
        end else begin
            compare_state(game_state, st_pc_turn, winner, m_winner);
            pc     = lfsr_coord(m_lfsr);
            m_lfsr = lfsr_next(m_lfsr);
            hit    = shot_outcome(m_home, pc);
            m_home[cell_index(pc)].hit = 1'b1;
            if (hit) m_home_afloat = m_home_afloat - 6'd1;
            exp_pc_q.push_back(make_resp(op_fire, 1'b0, hit));
            if (m_home_afloat == 6'd0) begin
                m_state  = st_game_over;
                m_winner = win_pc;
            end else begin
                m_state = st_player_turn;
            end
            wait (resp_count != start + 1);
            @(negedge clock);
            compare_state(game_state, m_state, winner, m_winner);
        end
    endtask

    // Responses are stable on the falling edge
    always @(negedge clock) begin : check_responses
        board_resp_t expected;
        if (!reset && player_result.valid) begin
            if (exp_player_q.size() == 0) begin
                note_failure("Target board responded without a player command");
            end else begin
                expected = exp_player_q.pop_front();
                compare_resp("player_result", player_result, expected);
            end
            compare_cells("target_view", target_view, m_target);
            compare_count("target_afloat", target_afloat, m_target_afloat);
            resp_count++;
        end
        if (!reset && pc_result.valid) begin
            if (exp_pc_q.size() == 0) begin
                note_failure("Home board responded without a command");
            end else begin
                expected = exp_pc_q.pop_front();
                compare_resp("pc_result", pc_result, expected);
            end
            compare_cells("home_view", home_view, m_home);
            compare_count("home_afloat", home_afloat, m_home_afloat);
            resp_count++;
        end
    end

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d clock cycles, the game never finished", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        coord_t shot;
        int     idx;
        seed         = 32'h5930_5ecd;
        reset        = 1'b1;
        place_button = 1'b0;
        fire_button  = 1'b0;
        target       = '0;
        m_home       = '0;
        m_target     = '0;
        m_home_afloat   = 6'd0;
        m_target_afloat = 6'd0;
        m_state      = st_setup_home;
        m_winner     = win_none;
        m_lfsr       = LFSR_SEED;
        m_ships      = 0;
        resp_count   = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        mark         = 0;
        repeat (16) @(negedge clock);
        reset = 1'b0;

        compare_state(game_state, st_setup_home, winner, win_none);
        compare_cells("home_view", home_view, m_home);
        compare_cells("target_view", target_view, m_target);
        compare_count("home_afloat", home_afloat, m_home_afloat);
        compare_count("target_afloat", target_afloat, m_target_afloat);
        repeat (10) @(negedge clock);
        if (resp_count != 0) note_failure("A board responded with no button pressed");
        end_test("reset");

        place_ship(coord_of(0, 0));  // Length 3 accepted
        place_ship(coord_of(0, 1));  // Overlap
        place_ship(coord_of(1, 4));  // Leaves the row
        place_ship(coord_of(1, 3));
        place_ship(coord_of(2, 0));
        place_ship(coord_of(4, 2));
        place_ship(coord_of(4, 1));  // Overlap on column 2
        place_ship(coord_of(3, 4));
        place_ship(coord_of(2, 2));
        place_ship(coord_of(0, 4));
        end_test("placement");

        fire_shot(coord_of(4, 2));  // Hit
        fire_shot(coord_of(0, 0));  // Water
        fire_shot(coord_of(4, 2));  // Repeat counts as a miss
        end_test("player shots");

        fire_shot(coord_of(1, 0));
        fire_shot(coord_of(1, 1));
        end_test("machine shots");

        while (m_state != st_game_over) begin
            do begin
                idx = int'($unsigned($random(seed)) % 32'(NCELL));
            end while (m_target[idx].hit);
            shot = coord_of(idx / BOARD_DIM, idx % BOARD_DIM);
            fire_shot(shot);
        end
        idx = resp_count;
        press_button(1'b1, coord_of(0, 0));
        press_button(1'b0, coord_of(3, 0));
        repeat (4) @(negedge clock);
        if (resp_count != idx) note_failure("A button press after the game ended reached a board");
        compare_state(game_state, m_state, winner, m_winner);
        compare_cells("home_view", home_view, m_home);
        compare_cells("target_view", target_view, m_target);
        compare_count("home_afloat", home_afloat, m_home_afloat);
        compare_count("target_afloat", target_afloat, m_target_afloat);
        if (exp_player_q.size() != 0 || exp_pc_q.size() != 0) begin
            note_failure("Expected board responses never arrived");
        end
        end_test("game end");

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
hdl/battle_types_pkg.sv
hdl/game_ctrl_pkg.sv
hdl/fleet_board.sv
hdl/shot_lfsr.sv
hdl/game_sequencer.sv
hdl/battleship_top.sv
sim/battleship_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := battleship_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
